// File: design/tcb_pkg.sv
/*
  Shared bus widths and request/response structs for the TCB interconnect.
  Import into any module that carries requests or responses.
*/

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////////

  // byte address
  localparam int unsigned ADR_W = 32;
  // read and write data
  localparam int unsigned DAT_W = 32;
  // one enable per data byte
  localparam int unsigned BEN_W = DAT_W / 8;

  //////////////////////////////////////////////////////////////////////////
  // request, sampled on a transfer
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic             wen;  // write enable
    logic [ADR_W-1:0] adr;  // byte address
    logic [BEN_W-1:0] ben;  // byte enables
    logic [DAT_W-1:0] wdt;  // write data
    logic             lck;  // hold grant after this transfer
    logic             rpt;  // repeat hint, no effect here
  } tcb_req_t;

  //////////////////////////////////////////////////////////////////////////
  // response, DLY cycles after the transfer
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [DAT_W-1:0] rdt;  // read data
    logic             err;  // address out of range
  } tcb_rsp_t;

endpackage : tcb_pkg

// File: design/tcb_arbiter.sv
/*
  Round-robin arbiter for the manager ports of the interconnect.
  Produces the port select for the request multiplexer; the lock bit of a
  transfer keeps the grant on the same port for the next transfer.
*/

`timescale 1ns/100ps

module tcb_arbiter #(
  parameter int unsigned PORTS = 3
)(
  input  logic                       man,
  input  logic                       rst_n,
  input  logic                       up_vld [PORTS],
  input  logic                       dn_vld,
  input  logic                       dn_lck,
  output logic [$clog2(PORTS)-1:0]   sel
);

  localparam int unsigned SEL_W = $clog2(PORTS);

  // last granted port
  logic [SEL_W-1:0] ptr;
  // grant held by lock
  logic             lck_q;

  // next valid port after the pointer
  logic [SEL_W-1:0] nxt;
  logic             fnd;

  //////////////////////////////////////////////////////////////////////////
  // arbiter state
  //////////////////////////////////////////////////////////////////////////

  // pointer starts on the last port so port 0 wins first
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      ptr   <= SEL_W'(PORTS - 1);
      lck_q <= 1'b0;
    end else if (dn_vld) begin
      // every downstream valid is a transfer
      ptr   <= sel;
      lck_q <= dn_lck;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // round-robin search
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    // no valid port, stay on pointer
    nxt = ptr;
    fnd = 1'b0;
    // rising index order, wrapping past the last port
    for (int k = 1; k <= PORTS; k++) begin
      if (!fnd && up_vld[(int'(ptr) + k) % PORTS]) begin
        nxt = SEL_W'((int'(ptr) + k) % PORTS);
        fnd = 1'b1;
      end
    end
  end

  // locked grant ignores other requests
  assign sel = lck_q ? ptr : nxt;

  // select must always point at an existing port
  sel_in_range: assert property (
    @(posedge man) disable iff (!rst_n)
    int'(sel) < PORTS
  );

endmodule : tcb_arbiter

// File: design/tcb_con_mux.sv
/*
  Request multiplexer and response router between manager ports and one
  subordinate. Request path is combinational from the select input; the
  select of each transfer is delayed DLY cycles to route the response.
*/

`timescale 1ns/100ps

module tcb_con_mux
  import tcb_pkg::*;
#(
  parameter int unsigned PORTS = 3,
  parameter int unsigned DLY   = 2
)(
  input  logic                       man,
  input  logic                       rst_n,
  // port select from arbiter
  input  logic [$clog2(PORTS)-1:0]   sel,
  // manager ports
  input  logic                       up_vld [PORTS],
  input  tcb_req_t                   up_req [PORTS],
  output logic                       up_rdy [PORTS],
  output tcb_rsp_t                   up_rsp [PORTS],
  // subordinate side
  output logic                       dn_vld,
  output tcb_req_t                   dn_req,
  input  tcb_rsp_t                   dn_rsp
);

  localparam int unsigned SEL_W = $clog2(PORTS);

  // one entry per cycle of response delay
  typedef struct packed {
    logic             vld;  // transfer happened
    logic [SEL_W-1:0] sel;  // issuing port
  } route_t;

  route_t route_q [DLY];
  // entry whose response is on dn_rsp now
  route_t route;

  //////////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////////

  // granted port goes downstream, zero cycles
  assign dn_vld = up_vld[sel];
  assign dn_req = up_req[sel];

  //////////////////////////////////////////////////////////////////////////
  // response routing
  //////////////////////////////////////////////////////////////////////////

  // shift line, advances every cycle
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < DLY; k++) begin
        route_q[k] <= '0;
      end
    end else begin
      route_q[0] <= '{vld: dn_vld, sel: sel};
      for (int k = 1; k < DLY; k++) begin
        route_q[k] <= route_q[k-1];
      end
    end
  end

  // last stage matches the response of this cycle
  assign route = route_q[DLY-1];

  for (genvar i = 0; i < PORTS; i++) begin : gen_port
    // ready only toward the granted port
    assign up_rdy[i] = (sel == SEL_W'(i));
    // other ports get zeros
    assign up_rsp[i] = (route.vld && (route.sel == SEL_W'(i))) ? dn_rsp : '0;

    // a waiting manager must not change its request
    req_held: assert property (
      @(posedge man) disable iff (!rst_n)
      (up_vld[i] && !up_rdy[i]) |=> $stable(up_req[i])
    );
  end : gen_port

endmodule : tcb_con_mux

// File: design/tcb_mem.sv
/*
  Word memory subordinate with byte enables and a fixed response delay.
  Accepts a request every cycle; addresses past DEPTH words answer with err
  and zero data, and writes to them are dropped.
*/

`timescale 1ns/100ps

module tcb_mem
  import tcb_pkg::*;
#(
  parameter int unsigned DLY   = 2,
  parameter int unsigned DEPTH = 64
)(
  input  logic     man,
  input  logic     rst_n,
  input  logic     dn_vld,
  input  tcb_req_t dn_req,
  output tcb_rsp_t dn_rsp
);

  localparam int unsigned IDX_W = $clog2(DEPTH);

  // storage
  logic [DAT_W-1:0] mem [DEPTH];

  // word address from byte address
  logic [ADR_W-3:0] wrd;
  logic             in_rng;
  logic [IDX_W-1:0] idx;

  // response pipeline
  tcb_rsp_t         rsp_q [DLY];
  logic             vld_q [DLY];

  assign wrd    = dn_req.adr[ADR_W-1:2];
  assign in_rng = (wrd < (ADR_W-2)'(DEPTH));
  assign idx    = wrd[IDX_W-1:0];

  //////////////////////////////////////////////////////////////////////////
  // write with byte enables
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge man) begin
    if (dn_vld && dn_req.wen && in_rng) begin
      for (int b = 0; b < BEN_W; b++) begin
        if (dn_req.ben[b]) begin
          mem[idx][8*b +: 8] <= dn_req.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // response pipeline
  //////////////////////////////////////////////////////////////////////////

  // payload, loaded only on a transfer
  always_ff @(posedge man) begin
    if (dn_vld) begin
      rsp_q[0].rdt <= (in_rng && !dn_req.wen) ? mem[idx] : '0;
      rsp_q[0].err <= !in_rng;
    end
    for (int k = 1; k < DLY; k++) begin
      rsp_q[k] <= rsp_q[k-1];
    end
  end

  // valid flags, empty after reset
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < DLY; k++) begin
        vld_q[k] <= 1'b0;
      end
    end else begin
      vld_q[0] <= dn_vld;
      for (int k = 1; k < DLY; k++) begin
        vld_q[k] <= vld_q[k-1];
      end
    end
  end

  // idle cycles drive zeros
  assign dn_rsp = vld_q[DLY-1] ? rsp_q[DLY-1] : '0;

  // an unknown valid would corrupt memory and routing
  vld_known: assert property (
    @(posedge man) disable iff (!rst_n)
    !$isunknown(dn_vld)
  );

endmodule : tcb_mem

// File: design/tcb_top.sv
/*
  Interconnect top level: PORTS managers share one memory through the
  round-robin arbiter and the request multiplexer.
*/

`timescale 1ns/100ps

module tcb_top
  import tcb_pkg::*;
#(
  parameter int unsigned PORTS = 3,
  parameter int unsigned DLY   = 2,
  parameter int unsigned DEPTH = 64
)(
  input  logic     man,
  input  logic     rst_n,
  // manager ports
  input  logic     up_vld [PORTS],
  input  tcb_req_t up_req [PORTS],
  output logic     up_rdy [PORTS],
  output tcb_rsp_t up_rsp [PORTS]
);

  localparam int unsigned SEL_W = $clog2(PORTS);

  // granted port
  logic [SEL_W-1:0] sel;
  // memory side of the multiplexer
  logic             dn_vld;
  tcb_req_t         dn_req;
  tcb_rsp_t         dn_rsp;

  //////////////////////////////////////////////////////////////////////////
  // arbiter, multiplexer, memory
  //////////////////////////////////////////////////////////////////////////

  tcb_arbiter #(
    .PORTS (PORTS)
  ) arb_i (
    .man    (man),
    .rst_n  (rst_n),
    .up_vld (up_vld),
    .dn_vld (dn_vld),
    .dn_lck (dn_req.lck),
    .sel    (sel)
  );

  tcb_con_mux #(
    .PORTS (PORTS),
    .DLY   (DLY)
  ) mux_i (
    .man    (man),
    .rst_n  (rst_n),
    .sel    (sel),
    .up_vld (up_vld),
    .up_req (up_req),
    .up_rdy (up_rdy),
    .up_rsp (up_rsp),
    .dn_vld (dn_vld),
    .dn_req (dn_req),
    .dn_rsp (dn_rsp)
  );

  tcb_mem #(
    .DLY   (DLY),
    .DEPTH (DEPTH)
  ) mem_i (
    .man    (man),
    .rst_n  (rst_n),
    .dn_vld (dn_vld),
    .dn_req (dn_req),
    .dn_rsp (dn_rsp)
  );

endmodule : tcb_top

// File: verif/tcb_tb.sv
/*
  Directed testbench for the TCB interconnect top level.
  Drives three manager ports, mirrors the memory in a word model and checks
  every response, the grant order and the response timing.
*/

`timescale 1ns/100ps

module tcb_tb
  import tcb_pkg::*;
();

  localparam int unsigned PORTS = 3;
  localparam int unsigned DLY   = 2;
  localparam int unsigned DEPTH = 64;
  localparam int unsigned SEL_W = $clog2(PORTS);
  localparam int unsigned IDX_W = $clog2(DEPTH);
  // worst case per access: grant wait, response delay, spacing
  localparam int unsigned ACC_CYC = DLY + 6;
  // two resets, about 30 accesses, burst and margin
  localparam int unsigned RUN_CYC = 2 * 16 + 40 * ACC_CYC + 100;

  typedef logic [SEL_W-1:0] sel_t;

  logic     man;
  logic     rst_n;
  logic     up_vld [PORTS];
  tcb_req_t up_req [PORTS];
  logic     up_rdy [PORTS];
  tcb_rsp_t up_rsp [PORTS];

  // word model of the memory
  logic [DAT_W-1:0] ref_mem [DEPTH];
  // port seen granted on each transfer
  sel_t             grant_log [$];
  int               seed;

  tcb_top #(
    .PORTS (PORTS),
    .DLY   (DLY),
    .DEPTH (DEPTH)
  ) dut_i (
    .man    (man),
    .rst_n  (rst_n),
    .up_vld (up_vld),
    .up_req (up_req),
    .up_rdy (up_rdy),
    .up_rsp (up_rsp)
  );

  // 100 ns period
  always #50 man = ~man;

  ////////////////////////////////////////////////////////////////////////////
  // model and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic tcb_req_t make_req(input logic wen, input int unsigned wrd,
                                        input logic [BEN_W-1:0] ben,
                                        input logic [DAT_W-1:0] wdt, input logic lck);
    tcb_req_t req;
    req.wen = wen;
    req.adr = ADR_W'(wrd * 4);
    req.ben = ben;
    req.wdt = wdt;
    req.lck = lck;
    req.rpt = 1'b0;
    return req;
  endfunction

  // expected response, model updated on in-range writes
  function automatic tcb_rsp_t model_access(input tcb_req_t req);
    tcb_rsp_t         rsp;
    int unsigned      wrd;
    logic [IDX_W-1:0] idx;
    rsp = '0;
    wrd = req.adr >> 2;
    idx = wrd[IDX_W-1:0];
    if (wrd >= DEPTH) begin
      rsp.err = 1'b1;
    end else if (req.wen) begin
      // byte merge
      for (int b = 0; b < BEN_W; b++) begin
        if (req.ben[b]) begin
          ref_mem[idx][8*b +: 8] = req.wdt[8*b +: 8];
        end
      end
    end else begin
      rsp.rdt = ref_mem[idx];
    end
    return rsp;
  endfunction

  // index of the port with ready high
  function automatic sel_t granted_port();
    sel_t idx;
    idx = '0;
    for (int k = PORTS - 1; k >= 0; k--) begin
      if (up_rdy[k]) begin
        idx = sel_t'(k);
      end
    end
    return idx;
  endfunction

  task automatic check_rsp(input string name, input tcb_rsp_t exp, input tcb_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected rdt=%h err=%b, actual rdt=%h err=%b",
                          name, exp.rdt, exp.err, act.rdt, act.err));
    end
  endtask

  task automatic check_port(input string name, input sel_t exp, input sel_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected port %0d, actual port %0d",
                          name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks, entered and left 10 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) @(posedge man);
    #10;
    rst_n = 1'b1;
  endtask

  // one request on port p, response checked DLY cycles after the transfer
  task automatic access(input int p, input tcb_req_t req, input string name);
    tcb_rsp_t exp;
    exp = model_access(req);
    up_vld[p] = 1'b1;
    up_req[p] = req;
    // ready sampled mid cycle, transfer on the next edge
    @(negedge man);
    while (!up_rdy[p]) begin
      @(negedge man);
    end
    grant_log.push_back(granted_port());
    @(posedge man);
    #10;
    up_vld[p] = 1'b0;
    // nothing for this port one cycle early
    repeat (DLY - 1) @(negedge man);
    check_rsp(name, '0, up_rsp[p]);
    @(negedge man);
    check_rsp(name, exp, up_rsp[p]);
    @(posedge man);
    #10;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_read_back();
    for (int i = 0; i < 6; i++) begin
      access(i % PORTS, make_req(1'b1, i, 4'hF, $random(seed), 1'b0), "write_read_back");
    end
    // read from a different port than the writer
    for (int i = 0; i < 6; i++) begin
      access((i + 1) % PORTS, make_req(1'b0, i, '0, '0, 1'b0), "write_read_back");
    end
  endtask

  task automatic byte_enable_merge();
    access(0, make_req(1'b1, 2, 4'b0101, $random(seed), 1'b0), "byte_enable_merge");
    access(1, make_req(1'b1, 2, 4'b1000, $random(seed), 1'b0), "byte_enable_merge");
    access(2, make_req(1'b0, 2, '0, '0, 1'b0), "byte_enable_merge");
  endtask

  task automatic range_error();
    // word DEPTH would alias word 0 without the range check
    access(1, make_req(1'b1, DEPTH, 4'hF, $random(seed), 1'b0), "range_error");
    access(2, make_req(1'b0, DEPTH + 1, '0, '0, 1'b0), "range_error");
    access(0, make_req(1'b0, 32'h3FFF_FFFC, '0, '0, 1'b0), "range_error");
    access(1, make_req(1'b0, 0, '0, '0, 1'b0), "range_error");
  endtask

  // run right after a reset, pointer on the last port
  task automatic round_robin_order();
    grant_log.delete();
    fork
      access(0, make_req(1'b0, 3, '0, '0, 1'b0), "round_robin_order");
      access(1, make_req(1'b0, 4, '0, '0, 1'b0), "round_robin_order");
      access(2, make_req(1'b0, 5, '0, '0, 1'b0), "round_robin_order");
    join
    for (int i = 0; i < 3; i++) begin
      check_port("round_robin_order", sel_t'(i), grant_log[i]);
    end
  endtask

  task automatic lock_hold();
    int unsigned order [5];
    order = '{1, 1, 1, 2, 0};
    grant_log.delete();
    // first locked transfer, port 1 alone
    access(1, make_req(1'b1, 20, 4'hF, $random(seed), 1'b1), "lock_hold");
    fork
      access(0, make_req(1'b0, 0, '0, '0, 1'b0), "lock_hold");
      access(2, make_req(1'b0, 1, '0, '0, 1'b0), "lock_hold");
      begin
        access(1, make_req(1'b1, 21, 4'hF, $random(seed), 1'b1), "lock_hold");
        // lock released by this one
        access(1, make_req(1'b1, 22, 4'hF, $random(seed), 1'b0), "lock_hold");
      end
    join
    for (int i = 0; i < 5; i++) begin
      check_port("lock_hold", sel_t'(order[i]), grant_log[i]);
    end
  endtask

  // valid held high, one transfer per cycle
  task automatic pipelined_reads();
    tcb_rsp_t exp [4];
    for (int i = 0; i < 4; i++) begin
      exp[i] = model_access(make_req(1'b0, i, '0, '0, 1'b0));
    end
    up_vld[2] = 1'b1;
    up_req[2] = make_req(1'b0, 0, '0, '0, 1'b0);
    for (int c = 0; c < 4 + DLY; c++) begin
      @(negedge man);
      if (c < 4) begin
        check_port("pipelined_reads", sel_t'(2), granted_port());
      end
      if (c >= DLY) begin
        check_rsp("pipelined_reads", exp[c - DLY], up_rsp[2]);
      end else begin
        check_rsp("pipelined_reads", '0, up_rsp[2]);
      end
      @(posedge man);
      #10;
      if (c + 1 < 4) begin
        up_req[2] = make_req(1'b0, c + 1, '0, '0, 1'b0);
      end else begin
        up_vld[2] = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    man   = 1'b0;
    rst_n = 1'b0;
    seed  = 57778;
    for (int k = 0; k < PORTS; k++) begin
      up_vld[k] = 1'b0;
      up_req[k] = '0;
    end
    apply_reset();
    write_read_back();
    byte_enable_merge();
    range_error();
    // memory keeps its contents, arbiter starts over
    apply_reset();
    round_robin_order();
    lock_hold();
    pipelined_reads();
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    #(RUN_CYC * 100);
    abort_run($sformatf("timeout: no end of test after %0d cycles, a grant or response hung",
                        RUN_CYC));
  end

endmodule : tcb_tb

// File: project.f
design/tcb_pkg.sv
design/tcb_arbiter.sv
design/tcb_con_mux.sv
design/tcb_mem.sv
design/tcb_top.sv
verif/tcb_tb.sv

// File: Makefile
# Verilator flow for the TCB interconnect

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tcb_top -f project.f

# pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module tcb_tb -f project.f \
	  --Mdir obj_dir -o tcb_sim
	./obj_dir/tcb_sim | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
